//--- source/decode_macros.svh
/* widths and field positions of the 8-bit instruction encoding
   addresses are 12 bits wide but a two-byte instruction forms only the low 11 */
`ifndef DECODE_MACROS_SVH
`define DECODE_MACROS_SVH

`define DATA_W        8     // instruction and data byte
`define ADDR_W        12    // data and code address
`define REG_PTR_W     2

`define BASE_OP_LSB   5     // bits 7..5
`define BASE_OP_W     3
`define IMM_BIT       4     // ALU immediate flag
`define REG_PTR0_LSB  2
`define REG_PTR1_LSB  0

`define CTRL_OP_LSB   3     // MISC, USR, JMP, CALL
`define CTRL_OP_W     2
`define MISC_OP_W     3

`define LDST_REG_LSB  3
`define ADDR_HI_W     3     // high address bits held in the first byte

`endif

//--- source/decode_pkg.sv
/* types shared by the decode stage and its testbench */
`default_nettype none
`include "decode_macros.svh"

package decode_pkg;

    typedef enum logic [`BASE_OP_W-1:0] {
        OP_CTRL, OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_LD, OP_ST
    } base_op_t;

    // codes 3 and 7 are not listed and decode as illegal
    typedef enum logic [`MISC_OP_W-1:0] {
        MISC_NOP      = 3'd0,
        MISC_RET      = 3'd1,
        MISC_HALT     = 3'd2,
        MISC_SET_BCZ  = 3'd4,
        MISC_SET_BCNZ = 3'd5,
        MISC_CLR_BC   = 3'd6
    } misc_op_t;

    typedef enum logic [`CTRL_OP_W-1:0] {
        CTRL_MISC, CTRL_USR, CTRL_JMP, CTRL_CALL
    } ctrl_op_t;

    typedef enum logic [3:0] {
        EXEC_NOP, ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
        MEM_RD, MEM_WR, CPU_JMP, CPU_CALL, CPU_RET
    } exec_op_t;

    typedef struct packed {
        exec_op_t               ctrl;
        logic [`REG_PTR_W-1:0]  src0;
        logic                   src0_rd_en;
        logic [`REG_PTR_W-1:0]  src1;
        logic                   src1_rd_en;
        logic [`REG_PTR_W-1:0]  dst;
        logic [`ADDR_W-1:0]     addr;
        logic [`DATA_W-1:0]     imm_val;
        logic                   imm_vld;
    } exec_cmd_t;

    typedef struct packed {
        logic [2:0] reserved;
        logic       trap;
        logic       z;
        logic       nz;
        logic       st_ovf;
        logic       ovf;
    } status_t;

    typedef enum logic [1:0] {
        CR_HOLD, CR_SET_BCZ, CR_SET_BCNZ, CR_CLR
    } cr_cmd_t;

endpackage

`default_nettype wire

//--- source/opcode_decoder.sv
/* decodes one byte per cycle while decode_en is high into a registered command
   no back-pressure, execute takes every command the cycle it appears
   USR and MISC codes 3 and 7 are illegal and must never be sent */
`default_nettype none
`include "decode_macros.svh"

module opcode_decoder import decode_pkg::*; (
    input  wire                   clk,
    input  wire                   reset_,
    input  wire                   decode_en,
    input  wire [`DATA_W-1:0]     inst,
    input  wire                   branch_taken,
    input  wire                   ret_restore,
    output exec_cmd_t             exec_cmd,
    output logic                  exec_en_raw,
    output logic                  latch_ret_addr,
    output logic [`ADDR_W-1:0]    tgt_addr,
    output cr_cmd_t               cr_cmd,
    output logic                  ret_start,
    output logic                  halt_start,
    output logic                  fetch_req_set,
    output logic                  fetch_req_clr
);

    logic                   imm_mode;       // next byte is an operand byte
    logic [`DATA_W-1:0]     prev_inst;
    logic [`DATA_W-1:0]     curr_inst;
    logic                   imm_mode_next;
    logic                   exec_en_next;
    logic                   illegal;
    logic                   call_op;
    exec_cmd_t              cmd_next;
    exec_op_t               alu_ctrl;
    base_op_t               base_op;
    base_op_t               prev_base;
    ctrl_op_t               ctrl_op;
    misc_op_t               misc_op;
    logic [`REG_PTR_W-1:0]  ptr0;
    logic [`REG_PTR_W-1:0]  ptr1;
    logic [`REG_PTR_W-1:0]  ldst_reg;
    logic [`ADDR_W-1:0]     addr_formed;

    assign curr_inst = ret_restore ? '0 : inst;    // all zero is NOP
    assign base_op   = base_op_t'(curr_inst[`BASE_OP_LSB +: `BASE_OP_W]);
    assign prev_base = base_op_t'(prev_inst[`BASE_OP_LSB +: `BASE_OP_W]);
    assign ctrl_op   = ctrl_op_t'(curr_inst[`CTRL_OP_LSB +: `CTRL_OP_W]);
    assign misc_op   = misc_op_t'(curr_inst[`MISC_OP_W-1:0]);
    assign ptr0      = curr_inst[`REG_PTR0_LSB +: `REG_PTR_W];
    assign ptr1      = curr_inst[`REG_PTR1_LSB +: `REG_PTR_W];
    assign ldst_reg  = curr_inst[`LDST_REG_LSB +: `REG_PTR_W];

    // high bits from the opcode byte, low byte from the operand
    assign addr_formed = {{(`ADDR_W-`ADDR_HI_W-`DATA_W){1'b0}},
                          prev_inst[`ADDR_HI_W-1:0], curr_inst};
    assign tgt_addr       = addr_formed;
    assign latch_ret_addr = call_op;

    always_comb begin
        case (base_op)
            OP_SUB:  alu_ctrl = ALU_SUB;
            OP_AND:  alu_ctrl = ALU_AND;
            OP_OR:   alu_ctrl = ALU_OR;
            OP_XOR:  alu_ctrl = ALU_XOR;
            default: alu_ctrl = ALU_ADD;
        endcase
    end

    always_comb begin
        cmd_next            = exec_cmd;
        cmd_next.src0_rd_en = 1'b0;
        cmd_next.src1_rd_en = 1'b0;
        imm_mode_next       = imm_mode;
        exec_en_next        = 1'b0;
        cr_cmd              = CR_HOLD;
        ret_start           = 1'b0;
        halt_start          = 1'b0;
        fetch_req_set       = 1'b0;
        fetch_req_clr       = 1'b0;
        illegal             = 1'b0;
        call_op             = 1'b0;
        if (decode_en && imm_mode) begin
            imm_mode_next    = 1'b0;
            cmd_next.ctrl    = EXEC_NOP;
            cmd_next.imm_vld = 1'b1;
            case (prev_base)
                OP_CTRL: begin              // only JMP and CALL take a second byte
                    cmd_next.addr = addr_formed;
                    fetch_req_set = 1'b1;
                end
                OP_LD, OP_ST: cmd_next.addr = addr_formed;
                default:      cmd_next.imm_val = curr_inst;
            endcase
        end else if (decode_en) begin
            exec_en_next     = 1'b1;
            imm_mode_next    = 1'b0;
            cmd_next.ctrl    = EXEC_NOP;
            cmd_next.imm_vld = 1'b0;
            case (base_op)
                OP_CTRL: begin
                    case (ctrl_op)
                        CTRL_MISC: begin
                            case (misc_op)
                                MISC_NOP:      cmd_next.ctrl = EXEC_NOP;
                                MISC_RET: begin
                                    cmd_next.ctrl = CPU_RET;
                                    ret_start     = 1'b1;
                                    fetch_req_set = 1'b1;
                                end
                                MISC_HALT: begin
                                    halt_start    = 1'b1;
                                    fetch_req_clr = 1'b1;
                                end
                                MISC_SET_BCZ:  cr_cmd = CR_SET_BCZ;
                                MISC_SET_BCNZ: cr_cmd = CR_SET_BCNZ;
                                MISC_CLR_BC:   cr_cmd = CR_CLR;
                                default:       illegal = 1'b1;
                            endcase
                        end
                        CTRL_JMP: begin
                            imm_mode_next = 1'b1;
                            if (branch_taken) cmd_next.ctrl = CPU_JMP;  // else falls through
                        end
                        CTRL_CALL: begin
                            imm_mode_next = 1'b1;
                            cmd_next.ctrl = CPU_CALL;
                            call_op       = 1'b1;
                        end
                        default: illegal = 1'b1;                  // USR group
                    endcase
                end
                OP_LD: begin
                    imm_mode_next = 1'b1;
                    cmd_next.ctrl = MEM_RD;
                    cmd_next.dst  = ldst_reg;
                end
                OP_ST: begin
                    imm_mode_next       = 1'b1;
                    cmd_next.ctrl       = MEM_WR;
                    cmd_next.src0       = ldst_reg;
                    cmd_next.src0_rd_en = 1'b1;
                end
                default: begin                      // ALU ops
                    imm_mode_next       = curr_inst[`IMM_BIT];
                    cmd_next.ctrl       = alu_ctrl;
                    cmd_next.src0       = ptr0;
                    cmd_next.src0_rd_en = 1'b1;
                    cmd_next.dst        = ptr1;
                    if (!curr_inst[`IMM_BIT]) begin
                        cmd_next.src1       = ptr1;
                        cmd_next.src1_rd_en = 1'b1;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!reset_) begin
            imm_mode    <= 1'b0;
            prev_inst   <= '0;
            exec_cmd    <= '0;
            exec_en_raw <= 1'b0;
        end else begin
            imm_mode    <= imm_mode_next;
            exec_cmd    <= cmd_next;
            exec_en_raw <= exec_en_next;
            if (decode_en) prev_inst <= curr_inst;  // keeps the opcode across idle gaps
        end
    end

    // program image must not contain USR or reserved MISC codes
    a_no_illegal: assert property (@(posedge clk) disable iff (!reset_) !illegal);

endmodule

`default_nettype wire

//--- source/control_register.sv
/* branch mode bits and the jump condition
   with no mode bit set every jump is taken */
`default_nettype none

module control_register import decode_pkg::*; (
    input  wire       clk,
    input  wire       reset_,
    input  cr_cmd_t   cr_cmd,
    input  status_t   sr,
    output logic      branch_taken
);

    logic bcz;      // branch when zero
    logic bcnz;     // branch when nonzero

    always_ff @(posedge clk) begin
        if (!reset_) begin
            bcz  <= 1'b0;
            bcnz <= 1'b0;
        end else begin
            case (cr_cmd)
                CR_SET_BCZ: begin
                    bcz  <= 1'b1;
                    bcnz <= 1'b0;
                end
                CR_SET_BCNZ: begin
                    bcz  <= 1'b0;
                    bcnz <= 1'b1;
                end
                CR_CLR: begin
                    bcz  <= 1'b0;
                    bcnz <= 1'b0;
                end
                default: ;          // hold
            endcase
        end
    end

    assign branch_taken = !(bcz || bcnz)
                       || (bcnz && sr.nz)
                       || (bcz && sr.z);

    // the two modes are exclusive
    a_mode_onehot: assert property (@(posedge clk) disable iff (!reset_) !(bcz && bcnz));

endmodule

`default_nettype wire

//--- source/flow_control.sv
/* halt is sticky until reset
   a return holds fetch off for two cycles while its address is restored */
`default_nettype none

module flow_control (
    input  wire   clk,
    input  wire   reset_,
    input  wire   ret_start,
    input  wire   halt_start,
    input  wire   fetch_req_set,
    input  wire   fetch_req_clr,
    input  wire   exec_en_raw,
    output logic  fetch_en,
    output logic  exec_en,
    output logic  ret_restore
);

    logic halted;
    logic fetch_req;
    logic ret_q1;       // first restore cycle
    logic ret_q2;       // second restore cycle

    always_ff @(posedge clk) begin
        if (!reset_) begin
            halted    <= 1'b0;
            fetch_req <= 1'b1;      // fetch runs out of reset
            ret_q1    <= 1'b0;
            ret_q2    <= 1'b0;
        end else begin
            halted <= halted || halt_start;
            ret_q1 <= ret_start;
            ret_q2 <= ret_q1;
            if (fetch_req_clr) begin
                fetch_req <= 1'b0;
            end else if (fetch_req_set) begin
                fetch_req <= 1'b1;
            end
        end
    end

    assign ret_restore = ret_q1 || ret_q2;
    assign fetch_en    = fetch_req && !halted && !ret_restore;
    assign exec_en     = exec_en_raw && !halted;

    // fetch stays off once halted
    a_halt_no_fetch: assert property (@(posedge clk) disable iff (!reset_)
        halted |-> !fetch_en);

endmodule

`default_nettype wire

//--- source/decode_top.sv
/* decode stage top, bytes accepted every cycle decode_en is high
   tgt_addr is only meaningful while a second byte is presented */
`default_nettype none
`include "decode_macros.svh"

module decode_top import decode_pkg::*; (
    input  wire                  clk,
    input  wire                  reset_,
    input  wire                  decode_en,
    input  wire [`DATA_W-1:0]    inst,
    input  status_t              sr,
    output exec_cmd_t            exec_cmd,
    output logic                 exec_en,
    output logic                 fetch_en,
    output logic                 latch_ret_addr,
    output logic [`ADDR_W-1:0]   tgt_addr
);

    cr_cmd_t cr_cmd;
    logic    branch_taken;
    logic    ret_restore;
    logic    ret_start;
    logic    halt_start;
    logic    fetch_req_set;
    logic    fetch_req_clr;
    logic    exec_en_raw;       // before the halt mask

    opcode_decoder i_opcode_decoder (
        .clk            (clk),
        .reset_         (reset_),
        .decode_en      (decode_en),
        .inst           (inst),
        .branch_taken   (branch_taken),
        .ret_restore    (ret_restore),
        .exec_cmd       (exec_cmd),
        .exec_en_raw    (exec_en_raw),
        .latch_ret_addr (latch_ret_addr),
        .tgt_addr       (tgt_addr),
        .cr_cmd         (cr_cmd),
        .ret_start      (ret_start),
        .halt_start     (halt_start),
        .fetch_req_set  (fetch_req_set),
        .fetch_req_clr  (fetch_req_clr)
    );

    control_register i_control_register (
        .clk          (clk),
        .reset_       (reset_),
        .cr_cmd       (cr_cmd),
        .sr           (sr),
        .branch_taken (branch_taken)
    );

    flow_control i_flow_control (
        .clk           (clk),
        .reset_        (reset_),
        .ret_start     (ret_start),
        .halt_start    (halt_start),
        .fetch_req_set (fetch_req_set),
        .fetch_req_clr (fetch_req_clr),
        .exec_en_raw   (exec_en_raw),
        .fetch_en      (fetch_en),
        .exec_en       (exec_en),
        .ret_restore   (ret_restore)
    );

endmodule

`default_nettype wire

//--- tests/tb_clock_gen.sv
/* free-running clock for the testbench, first rising edge at half a period
   reset_ is held low over the first RESET_CYCLES rising edges */
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD       = 20,
    parameter int RESET_CYCLES = 3
) (
    output logic clk,
    output logic reset_
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        reset_ = 1'b0;
        #(PERIOD * RESET_CYCLES);   // released on a falling edge
        reset_ = 1'b1;
    end

endmodule

`default_nettype wire

//--- tests/decode_top_tb.sv
/* drives bytes on the falling edge and checks at the rising edge
   a reference model of the decode rules runs alongside the DUT
   stimulus never contains USR or reserved MISC codes */
`default_nettype none
`include "decode_macros.svh"

module decode_top_tb import decode_pkg::*; ();

    localparam int PERIOD       = 20;
    localparam int RESET_CYCLES = 3;
    localparam int N_ALU        = 32;
    localparam int N_PAIR       = 24;
    localparam int N_JMP        = 8;
    localparam int N_CALL       = 4;
    localparam int N_HALT       = 8;
    localparam int TOTAL_BYTES  = N_ALU + 1 + 2 * N_PAIR + 3 * (1 + 2 * N_JMP)
                                + 6 * N_CALL + 1 + N_HALT + 1;

    logic                clk;
    logic                reset_;
    logic                decode_en;
    logic [`DATA_W-1:0]  inst;
    status_t             sr;
    exec_cmd_t           exec_cmd;
    logic                exec_en;
    logic                fetch_en;
    logic                latch_ret_addr;
    logic [`ADDR_W-1:0]  tgt_addr;

    // reference model state, changed only on the falling edge
    logic                m_imm;         // next byte is an operand byte
    logic [`DATA_W-1:0]  m_first;
    logic                m_bcz;
    logic                m_bcnz;
    logic                m_halted;
    int                  m_ret_cnt;     // restore cycles still ahead
    exec_cmd_t           e_cmd;
    exec_cmd_t           e_mask;        // fields of e_cmd that are defined
    logic                e_exec_en;
    logic                e_fetch_en;
    logic                e_latch;
    logic                e_tgt_vld;
    logic [`ADDR_W-1:0]  e_tgt;

    logic [31:0]         rng_state;
    logic [31:0]         r;
    int                  i;
    int                  m;
    int                  bytes_sent;
    int                  cmd_errors;
    int                  enable_errors;
    int                  output_errors;

    tb_clock_gen #(.PERIOD(PERIOD), .RESET_CYCLES(RESET_CYCLES)) i_tb_clock_gen (
        .clk    (clk),
        .reset_ (reset_)
    );

    decode_top i_decode_top (
        .clk            (clk),
        .reset_         (reset_),
        .decode_en      (decode_en),
        .inst           (inst),
        .sr             (sr),
        .exec_cmd       (exec_cmd),
        .exec_en        (exec_en),
        .fetch_en       (fetch_en),
        .latch_ret_addr (latch_ret_addr),
        .tgt_addr       (tgt_addr)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    function automatic logic [2:0] random_alu_op(input logic [31:0] x);
        return 3'(32'd1 + x % 32'd5);   // ADD..XOR
    endfunction

    // steps the model by the byte the last rising edge accepted
    function automatic void apply_accepted();
        logic [`DATA_W-1:0] b;
        logic               taken;
        b = (m_ret_cnt > 0) ? 8'h00 : inst;      // NOP while the return address restores
        if (m_ret_cnt > 0)
            m_ret_cnt--;
        e_cmd.src0_rd_en = 1'b0;
        e_cmd.src1_rd_en = 1'b0;
        e_exec_en        = 1'b0;
        if (decode_en) begin
            e_mask            = '0;
            e_mask.src0_rd_en = 1'b1;
            e_mask.src1_rd_en = 1'b1;
            e_mask.imm_vld    = 1'b1;
            e_cmd.ctrl        = EXEC_NOP;
            e_cmd.imm_vld     = m_imm;
            if (m_imm) begin
                if (m_first[7:5] == 3'd0 || m_first[7:5] >= 3'd6) begin
                    e_cmd.addr  = {1'b0, m_first[2:0], b};
                    e_mask.addr = '1;
                end else begin
                    e_cmd.imm_val  = b;
                    e_mask.imm_val = '1;
                end
                m_imm = 1'b0;
            end else begin
                case (b[7:5])
                    3'd0: begin
                        case (b[4:0])
                            5'h01: begin
                                e_cmd.ctrl = CPU_RET;
                                m_ret_cnt  = 2;
                            end
                            5'h02:   m_halted = 1'b1;
                            5'h04:   {m_bcz, m_bcnz} = 2'b10;
                            5'h05:   {m_bcz, m_bcnz} = 2'b01;
                            5'h06:   {m_bcz, m_bcnz} = 2'b00;
                            default: ;
                        endcase
                        if (b[4:3] == 2'd2) begin       // JMP
                            taken = !(m_bcz || m_bcnz) || (m_bcnz && sr.nz)
                                 || (m_bcz && sr.z);
                            e_cmd.ctrl = taken ? CPU_JMP : EXEC_NOP;
                        end else if (b[4:3] == 2'd3) begin
                            e_cmd.ctrl = CPU_CALL;
                        end
                        m_imm = b[4];                   // JMP and CALL take an address byte
                    end
                    3'd6: begin
                        e_cmd.ctrl = MEM_RD;
                        e_cmd.dst  = b[4:3];
                        e_mask.dst = '1;
                        m_imm      = 1'b1;
                    end
                    3'd7: begin
                        e_cmd.ctrl       = MEM_WR;
                        e_cmd.src0       = b[4:3];
                        e_cmd.src0_rd_en = 1'b1;
                        e_mask.src0      = '1;
                        m_imm            = 1'b1;
                    end
                    default: begin
                        e_cmd.ctrl       = exec_op_t'({1'b0, b[7:5]});  // same order as base ops
                        e_cmd.src0       = b[3:2];
                        e_cmd.src0_rd_en = 1'b1;
                        e_cmd.src1       = b[1:0];
                        e_cmd.src1_rd_en = !b[4];
                        e_cmd.dst        = b[1:0];
                        e_mask.src0      = '1;
                        e_mask.src1      = {2{!b[4]}};
                        e_mask.dst       = '1;
                        m_imm            = b[4];
                    end
                endcase
                e_exec_en = !m_halted;
            end
            m_first = b;
        end
        e_fetch_en = !m_halted && m_ret_cnt == 0;
    endfunction

    task automatic send_byte(input logic en, input logic [`DATA_W-1:0] b);
        logic [31:0] s;
        @(negedge clk);
        apply_accepted();
        s         = next_rand();
        sr        = '0;
        sr.z      = s[3];
        sr.nz     = s[9];
        decode_en = en;
        inst      = b;
        // outputs formed from the byte on the bus this cycle
        e_latch   = en && !m_imm && m_ret_cnt == 0 && b[7:3] == 5'b00011;
        e_tgt_vld = en && m_imm && m_ret_cnt == 0
                 && (m_first[7:5] == 3'd0 || m_first[7:5] >= 3'd6);
        e_tgt     = {1'b0, m_first[2:0], b};
        bytes_sent++;
    endtask

    a_ctrl: assert property (@(posedge clk) disable iff (!reset_) exec_cmd.ctrl == e_cmd.ctrl)
        else begin
            cmd_errors++;
            $display("FAILED %0t: exec_cmd.ctrl differs, expected %0d", $time, e_cmd.ctrl);
        end
    a_fields: assert property (@(posedge clk) disable iff (!reset_)
        ((exec_cmd ^ e_cmd) & e_mask) == '0)
        else begin
            cmd_errors++;
            $display("FAILED %0t: exec_cmd fields differ, expected %h mask %h", $time,
                     e_cmd, e_mask);
        end
    a_exec_en: assert property (@(posedge clk) disable iff (!reset_) exec_en == e_exec_en)
        else begin
            enable_errors++;
            $display("FAILED %0t: exec_en differs, expected %b", $time, e_exec_en);
        end
    a_fetch_en: assert property (@(posedge clk) disable iff (!reset_) fetch_en == e_fetch_en)
        else begin
            enable_errors++;
            $display("FAILED %0t: fetch_en differs, expected %b", $time, e_fetch_en);
        end
    a_latch: assert property (@(posedge clk) disable iff (!reset_) latch_ret_addr == e_latch)
        else begin
            output_errors++;
            $display("FAILED %0t: latch_ret_addr differs, expected %b", $time, e_latch);
        end
    a_tgt: assert property (@(posedge clk) disable iff (!reset_) e_tgt_vld |-> tgt_addr == e_tgt)
        else begin
            output_errors++;
            $display("FAILED %0t: tgt_addr differs, expected %h", $time, e_tgt);
        end

    initial begin
        #((RESET_CYCLES + TOTAL_BYTES + 10) * PERIOD);
        $display("timeout: stimulus stalled after %0d bytes", bytes_sent);
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial begin
        decode_en     = 1'b0;
        inst          = '0;
        sr            = '0;
        rng_state     = 32'd15626;
        bytes_sent    = 0;
        cmd_errors    = 0;
        enable_errors = 0;
        output_errors = 0;
        m_imm         = 1'b0;
        m_first       = '0;
        m_bcz         = 1'b0;
        m_bcnz        = 1'b0;
        m_halted      = 1'b0;
        m_ret_cnt     = 0;
        e_cmd         = '0;         // reset state, all fields checked
        e_mask        = '1;
        e_exec_en     = 1'b0;
        e_fetch_en    = 1'b1;
        e_latch       = 1'b0;
        e_tgt_vld     = 1'b0;
        e_tgt         = '0;
        wait (reset_ === 1'b1);
        @(posedge clk);

        for (i = 0; i < N_ALU; i++) begin
            r = next_rand();
            send_byte(1'b1, {random_alu_op(r), 1'b0, r[11:8]});
        end
        send_byte(1'b0, 8'h00);     // idle, read enables drop

        for (i = 0; i < N_PAIR; i++) begin
            r = next_rand();
            case (r[1:0])
                2'd0:    send_byte(1'b1, {3'd6, r[12:8]});      // LD
                2'd1:    send_byte(1'b1, {3'd7, r[12:8]});      // ST
                default: send_byte(1'b1, {random_alu_op(r), 1'b1, r[11:8]});
            endcase
            send_byte(1'b1, r[23:16]);
        end

        for (m = 0; m < 3; m++) begin
            send_byte(1'b1, 8'h04 + 8'(m));    // SET_BCZ, SET_BCNZ, CLR_BC
            for (i = 0; i < N_JMP; i++) begin
                r = next_rand();
                send_byte(1'b1, {5'b00010, r[2:0]});
                send_byte(1'b1, r[15:8]);
            end
        end

        for (i = 0; i < N_CALL; i++) begin
            r = next_rand();
            send_byte(1'b1, {5'b00011, r[2:0]});
            send_byte(1'b1, r[15:8]);
            send_byte(1'b1, 8'h01);                     // RET
            send_byte(1'b1, {3'd1, 1'b0, r[19:16]});    // dropped during restore
            send_byte(1'b1, {3'd2, 1'b0, r[23:20]});
            send_byte(1'b1, {3'd3, 1'b0, r[27:24]});
        end

        send_byte(1'b1, 8'h02);     // HALT
        for (i = 0; i < N_HALT; i++) begin
            r = next_rand();
            send_byte(1'b1, {random_alu_op(r), 1'b0, r[11:8]});
        end
        send_byte(1'b0, 8'h00);
        @(negedge clk);

        $display("%0d bytes sent, errors: exec_cmd %0d, enables %0d, latch/target %0d",
                 bytes_sent, cmd_errors, enable_errors, output_errors);
        if (cmd_errors + enable_errors + output_errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- decode_top.f
+incdir+source
source/decode_pkg.sv
source/opcode_decoder.sv
source/control_register.sv
source/flow_control.sv
source/decode_top.sv
tests/tb_clock_gen.sv
tests/decode_top_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# builds the decode stage testbench with Verilator and runs it
# exits non-zero when the build fails or the log reports a failure

cd "$(dirname "$0")" || exit 1

TOP=decode_top_tb
BUILD_DIR=obj_dir
BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -j 0 \
    --top-module "$TOP" \
    --Mdir "$BUILD_DIR" \
    -f decode_top.f > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
    cat "$BUILD_LOG"
    echo "build failed"
    exit 1
fi

"./$BUILD_DIR/V$TOP" > "$SIM_LOG" 2>&1
sim_status=$?
cat "$SIM_LOG"
if [ $sim_status -ne 0 ]; then
    echo "simulator exited with status $sim_status"
    exit 1
fi

if grep -q "Simulation finished: FAIL" "$SIM_LOG"; then
    exit 1
fi
if ! grep -q "Simulation finished: PASS" "$SIM_LOG"; then
    echo "no result line found in $SIM_LOG"
    exit 1
fi
exit 0
